/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_ldpc_dec_vnode_unit
FILELIST   := tb.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert -Wall
PASS_MSG   := *** PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_ldpc_dec_vnode_unit.sv */
//------------------------------------------------
// testbench of the variable node unit
// beat table with directed and random frames,
// reference model, output queues, stall check
//------------------------------------------------
`timescale 1ns/1ps
`include "ldpc_dec_cfg.svh"

module tb_ldpc_dec_vnode_unit import ldpc_dec_pkg::*; ();

  localparam int DEG  = `LDPC_COL_DEG;
  localparam int NW   = `LDPC_NODE_W;
  localparam int NMAX = 2**(NW-1) - 1;    // node range
  localparam int NMIN = -(2**(NW-1));
  localparam int NB   = 64;               // table rows

  // expected beat, tag is the enabled cycle where it must show up
  typedef struct packed {
    int                     tag;
    int                     idx;
    logic                   bdat;
    logic                   bflip;
    logic [DEG-1:0][NW-1:0] vn;
    logic [DEG-1:0][1:0]    vs;
  } exp_t;

  typedef struct packed {
    int tag;
    int bits;
    int flips;
  } rep_t;

  // DUT ports
  logic                   iclk;
  logic                   ireset;
  logic                   clkena;
  logic                   sop;
  logic                   val;
  logic                   eop;
  llr_t                   llr;
  node_t                  cnode  [DEG];
  node_state_t            cstate [DEG];
  logic                   vsop;
  logic                   vval;
  logic                   veop;
  node_t                  vnode  [DEG];
  node_state_t            vstate [DEG];
  logic                   bit_val;
  logic                   bit_dat;
  logic                   frame_done;
  logic [`LDPC_CNT_W-1:0] frame_bits;
  logic [`LDPC_CNT_W-1:0] frame_flips;
  logic                   seq_err;

  //------------------------------------------------
  // beat table
  //------------------------------------------------
  string bname [NB];
  bit    bsop  [NB];
  bit    beop  [NB];
  int    bllr  [NB];
  int    bnode [NB][DEG];
  int    bst   [NB][DEG];   // {pre_sign, pre_zero}
  int    bhold [NB];        // clkena low cycles before the beat
  int    nbeats;

  exp_t  bit_q  [$];        // expected outputs in order
  exp_t  msg_q  [$];
  rep_t  done_q [$];
  rep_t  err_q  [$];

  int    errors;
  int    checks;
  int    ecnt;              // enabled cycles since reset
  int    cur_idx;           // row on the input now
  int    f_bits;            // frame model
  int    f_flips;
  bit    f_open;
  logic  stalled;
  logic [127:0] snap;

  ldpc_dec_vnode_unit uut (.*);

  initial begin
    iclk = 1'b0;
    forever #2 iclk = ~iclk;    // 4 ns
  end

  task automatic add_beat(input string name, input bit s, input bit e, input int l,
                          input int c0, input int c1, input int c2,
                          input logic [5:0] st, input int hold);
    bname[nbeats] = name;
    bsop[nbeats]  = s;
    beop[nbeats]  = e;
    bllr[nbeats]  = l;
    bnode[nbeats][0] = c0;
    bnode[nbeats][1] = c1;
    bnode[nbeats][2] = c2;
    for (int c = 0; c < DEG; c++) bst[nbeats][c] = int'(st[2*c +: 2]);
    bhold[nbeats] = hold;
    nbeats++;
  endtask

  // rules of the unit, one beat
  function automatic exp_t compute_expect(input int i);
    exp_t e;
    int   s;
    int   x;
    int   n;
    e     = '0;
    e.idx = i;
    s     = bllr[i] * (2 ** (`LDPC_NODE_W - `LDPC_LLR_W));   // llr on node scale
    for (int c = 0; c < DEG; c++) s += bnode[i][c];
    e.bdat  = (s < 0);
    e.bflip = e.bdat ^ (bllr[i] <= 0);
    for (int c = 0; c < DEG; c++) begin
      x = s - bnode[i][c];                                   // extrinsic
      if (`LDPC_USE_SC_MODE != 0 && bst[i][c][0] == 1'b0 && bst[i][c][1] != (x < 0))
        n = 0;
      else if (`LDPC_USE_NORM != 0)
        n = (x * `LDPC_NORM_FACTOR + 4) >>> 3;
      else
        n = x;
      e.vs[c] = (`LDPC_USE_SC_MODE != 0) ? {n < 0, n == 0} : 2'b00;
      if (n > NMAX) n = NMAX;
      else if (n < NMIN) n = NMIN;
      e.vn[c] = n[NW-1:0];
    end
    return e;
  endfunction

  task automatic check_value(input string name, input string what,
                             input logic signed [31:0] exp, input logic signed [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("[ERROR] %s %s: expected %0d actual %0d", name, what, exp, act);
    end
  endtask

  // every output bit in one word, for the stall check
  function automatic logic [127:0] out_word();
    logic [127:0] w;
    w = {vsop, vval, veop, bit_val, bit_dat, frame_done, seq_err, frame_bits, frame_flips};
    for (int c = 0; c < DEG; c++) w = {w[119:0], vnode[c], vstate[c]};
    return w;
  endfunction

  task automatic drive_beat(input int i);
    @(posedge iclk);
    #1;
    if (bhold[i] > 0) begin
      clkena = 1'b0;            // stall mid frame
      val    = 1'b0;
      repeat (bhold[i]) begin
        @(posedge iclk);
        #1;
      end
      clkena = 1'b1;
    end
    cur_idx = i;
    sop     = bsop[i];
    eop     = beop[i];
    val     = 1'b1;
    llr     = llr_t'(bllr[i]);
    for (int c = 0; c < DEG; c++) begin
      cnode[c]  = node_t'(bnode[i][c]);
      cstate[c] = node_state_t'(bst[i][c][1:0]);
    end
  endtask

  //------------------------------------------------
  // monitor, samples on the falling edge
  //------------------------------------------------
  always @(negedge iclk) begin : monitor
    exp_t e;
    rep_t r;
    bit   dup;
    if (!ireset) begin
      if (stalled) begin
        assert (out_word() === snap) else begin
          errors++;
          $display("outputs changed while clkena was low at %0t", $time);
        end
      end
      if (clkena) begin
        if (val) begin
          e     = compute_expect(cur_idx);
          e.tag = ecnt + 2;                  // bit stream latency
          bit_q.push_back(e);
          e.tag = ecnt + 4;                  // message stream latency
          msg_q.push_back(e);
          r     = '{tag: ecnt + 3, bits: 0, flips: 0};
          dup   = sop && f_open;
          if (dup) err_q.push_back(r);       // sop inside a frame
          if (sop) begin
            f_bits  = 0;
            f_flips = 0;
          end
          if (sop || f_open) begin
            f_bits++;
            f_flips += e.bflip;
            if (eop && !dup) done_q.push_back('{tag: ecnt + 3, bits: f_bits, flips: f_flips});
            f_open = !eop;
          end else if (eop) begin
            err_q.push_back(r);              // stray eop
          end
        end
        if (bit_val) begin
          if (bit_q.size() == 0) begin
            errors++;
            $display("bit_val seen with no beat pending at %0t", $time);
          end else begin
            e = bit_q.pop_front();
            check_value(bname[e.idx], "bit latency", e.tag, ecnt);
            check_value(bname[e.idx], "bit_dat", e.bdat, bit_dat);
          end
        end
        if (vval) begin
          if (msg_q.size() == 0) begin
            errors++;
            $display("vval seen with no beat pending at %0t", $time);
          end else begin
            e = msg_q.pop_front();
            check_value(bname[e.idx], "message latency", e.tag, ecnt);
            check_value(bname[e.idx], "vsop", bsop[e.idx], vsop);
            check_value(bname[e.idx], "veop", beop[e.idx], veop);
            for (int c = 0; c < DEG; c++) begin
              check_value(bname[e.idx], $sformatf("vnode[%0d]", c), $signed(e.vn[c]), vnode[c]);
              check_value(bname[e.idx], $sformatf("vstate[%0d]", c), e.vs[c], vstate[c]);
            end
          end
        end
        if (frame_done) begin
          if (done_q.size() == 0) begin
            errors++;
            $display("frame_done pulsed with no frame closed at %0t", $time);
          end else begin
            r = done_q.pop_front();
            check_value("frame", "done latency", r.tag, ecnt);
            check_value("frame", "frame_bits", r.bits, frame_bits);
            check_value("frame", "frame_flips", r.flips, frame_flips);
          end
        end
        if (seq_err) begin
          if (err_q.size() == 0) begin
            errors++;
            $display("seq_err pulsed on good framing at %0t", $time);
          end else begin
            r = err_q.pop_front();
            check_value("framing", "seq_err latency", r.tag, ecnt);
          end
        end
        ecnt++;
      end
      stalled = !clkena;
      snap    = out_word();
    end
  end

  //------------------------------------------------
  // main sequence
  //------------------------------------------------
  initial begin : main
    int len;
    int wait_cnt;
    void'($urandom(87094));
    errors = 0;
    checks = 0;
    ecnt   = 0;
    nbeats = 0;
    f_open = 1'b0;
    stalled = 1'b0;
    ireset = 1'b1;
    clkena = 1'b1;
    sop    = 1'b0;
    val    = 1'b0;
    eop    = 1'b0;
    llr    = '0;
    for (int c = 0; c < DEG; c++) begin
      cnode[c]  = '0;
      cstate[c] = '0;
    end

    // directed frame, sc off per edge unless pre_zero is cleared
    add_beat("pos_sum",  1, 0,   5,   3,   4,  -2, 6'b010101, 0);
    add_beat("zero_sum", 0, 0,  -2,   2,   1,   1, 6'b010101, 0);
    add_beat("neg_llr",  0, 0,  -7,  -3,   5,  -1, 6'b010101, 0);
    add_beat("pos_ovf",  0, 0,  15,  31,  31,  31, 6'b010101, 0);
    add_beat("neg_ovf",  0, 0, -16, -32, -32, -32, 6'b010101, 5);
    add_beat("sc_zero",  0, 0,   4,   2,   3,   1, 6'b101010, 0);
    add_beat("sc_keep",  0, 1,   4,   2,   3,   1, 6'b111111, 0);
    // framing errors
    add_beat("dup_sop_a", 1, 0, 3, 1, 2, 3, 6'b010101, 0);
    add_beat("dup_sop_b", 1, 0, -3, 4, -5, 6, 6'b010101, 0);
    add_beat("dup_sop_c", 0, 1, 6, -7, 8, -9, 6'b010101, 0);
    add_beat("stray_eop", 0, 1, 2, 2, 2, 2, 6'b010101, 0);
    // random frames back to back
    for (int f = 0; f < 4; f++) begin
      len = $urandom_range(6, 1);
      for (int b = 0; b < len; b++) begin
        add_beat($sformatf("rand_f%0d_b%0d", f, b), b == 0, b == len - 1,
                 int'($urandom_range(31)) - 16, int'($urandom_range(63)) - 32,
                 int'($urandom_range(63)) - 32, int'($urandom_range(63)) - 32,
                 6'($urandom_range(63)), (f == 1 && b == 1) ? 3 : 0);
      end
    end

    repeat (10) @(posedge iclk);
    #1;
    ireset = 1'b0;
    check_value("reset", "vval", 0, vval);
    check_value("reset", "bit_val", 0, bit_val);
    check_value("reset", "frame_done", 0, frame_done);
    check_value("reset", "seq_err", 0, seq_err);

    for (int i = 0; i < nbeats; i++) drive_beat(i);
    @(posedge iclk);
    #1;
    val = 1'b0;
    sop = 1'b0;
    eop = 1'b0;

    // drain the pipeline
    wait_cnt = 0;
    while ((bit_q.size() + msg_q.size() + done_q.size() + err_q.size()) != 0 &&
           wait_cnt < 100) begin
      @(posedge iclk);
      wait_cnt++;
    end
    if (wait_cnt >= 100) begin
      errors++;
      $display("timeout, expected outputs never appeared");
    end
    repeat (5) @(posedge iclk);   // catch late spurious pulses

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* design/ldpc_dec_bit_stat.sv */
//------------------------------------------------
// per frame statistics of the hard decisions
// bit and flip counters, framing check, report
//------------------------------------------------
`timescale 1ns/1ps
`include "ldpc_dec_cfg.svh"

module ldpc_dec_bit_stat import ldpc_dec_pkg::*; (
  input  logic                   iclk,
  input  logic                   ireset,
  input  logic                   clkena,
  // bit stream from the engine
  input  logic                   bit_sop,
  input  logic                   bit_val,
  input  logic                   bit_eop,
  input  logic                   bit_dat,
  input  logic                   bit_flip,
  // frame report
  output logic                   frame_done,   // one pulse per good frame
  output logic                   seq_err,      // broken sop/eop framing
  output logic [`LDPC_CNT_W-1:0] frame_bits,
  output logic [`LDPC_CNT_W-1:0] frame_flips
);

  localparam int W = `LDPC_CNT_W;

  stat_state_t  state;
  logic [W-1:0] bit_cnt;     // beats so far in the open frame
  logic [W-1:0] flip_cnt;    // flipped decisions so far
  logic [W-1:0] bits_nxt;
  logic [W-1:0] flips_nxt;
  logic         open_beat;   // beat that belongs to a frame

  // sop restarts the count at this beat
  always_comb begin
    if (bit_sop) begin
      bits_nxt  = W'(1);
      flips_nxt = W'(bit_flip);
    end else begin
      bits_nxt  = bit_cnt + 1'b1;
      flips_nxt = flip_cnt + W'(bit_flip);
    end
  end

  // the decided bit itself is not counted, only its flip flag
  assign open_beat = bit_val & (bit_sop | (state == ST_FRAME));

  //------------------------------------------------
  // FSM and counters
  //------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state       <= ST_IDLE;
      bit_cnt     <= '0;
      flip_cnt    <= '0;
      frame_bits  <= '0;
      frame_flips <= '0;
      frame_done  <= 1'b0;
      seq_err     <= 1'b0;
    end else if (clkena) begin
      frame_done <= 1'b0;            // pulses
      seq_err    <= 1'b0;
      if (open_beat) begin
        bit_cnt  <= bits_nxt;
        flip_cnt <= flips_nxt;
        state    <= bit_eop ? ST_IDLE : ST_FRAME;
        if (bit_sop && state == ST_FRAME) begin
          seq_err <= 1'b1;           // sop inside a frame, no report on this beat
        end else if (bit_eop) begin
          frame_done  <= 1'b1;
          frame_bits  <= bits_nxt;   // latch totals including this beat
          frame_flips <= flips_nxt;
        end
      end else if (bit_val && bit_eop) begin
        seq_err <= 1'b1;             // stray eop outside a frame
      end
    end
  end

  a_done_err_excl : assert property (@(posedge iclk) disable iff (ireset)
    !(frame_done && seq_err));
  // a valid beat carries a decided bit, x would mean a dead stream
  a_bit_known     : assert property (@(posedge iclk) disable iff (ireset)
    bit_val |-> !$isunknown(bit_dat));

endmodule

/* design/ldpc_dec_cfg.svh */
//------------------------------------------------
// configuration macros of the variable node unit
// word widths, column degree, normalization
// factor, mode switches and counter width
//------------------------------------------------

`ifndef LDPC_DEC_CFG_SVH
`define LDPC_DEC_CFG_SVH

// fixed point word widths
`define LDPC_LLR_W        5   // channel llr, signed
`define LDPC_NODE_W       6   // node message, signed

// code structure
`define LDPC_COL_DEG      3   // check node messages per bit

// normalization numerator over 8, one of 4..7
// 6 gives 0.75
`define LDPC_NORM_FACTOR  6

// mode switches
`define LDPC_USE_NORM     1   // scale extrinsic messages
`define LDPC_USE_SC_MODE  1   // zero messages whose sign flipped

// frame statistics
`define LDPC_CNT_W        12  // bits per frame counter

`endif

/* design/ldpc_dec_pkg.sv */
//------------------------------------------------
// shared types of the variable node unit
// llr and message words, message state, stats FSM
//------------------------------------------------

`include "ldpc_dec_cfg.svh"

package ldpc_dec_pkg;

  //------------------------------------------------
  // data words
  //------------------------------------------------

  // channel llr as it comes from the demapper
  typedef logic signed [`LDPC_LLR_W-1:0]  llr_t;

  // check to variable and variable to check message
  typedef logic signed [`LDPC_NODE_W-1:0] node_t;

  // state of a message from the previous iteration, used by sc rule
  typedef struct packed {
    logic pre_sign;   // message was negative
    logic pre_zero;   // message was zero (erased)
  } node_state_t;

  //------------------------------------------------
  // statistics FSM
  //------------------------------------------------

  typedef enum logic {
    ST_IDLE,          // waiting for sop
    ST_FRAME          // frame open, counting beats
  } stat_state_t;

endpackage

/* design/ldpc_dec_vnode_engine.sv */
//------------------------------------------------
// variable node engine of the min-sum decoder
// adder tree for the a-posteriori sum, hard bit,
// extrinsic messages with normalization, sc rule
// and saturation
//------------------------------------------------
`timescale 1ns/1ps
`include "ldpc_dec_cfg.svh"

module ldpc_dec_vnode_engine import ldpc_dec_pkg::*; (
  input  logic        iclk,
  input  logic        ireset,
  input  logic        clkena,
  // input beat
  input  logic        sop,
  input  logic        val,
  input  logic        eop,
  input  llr_t        llr,
  input  node_t       cnode  [`LDPC_COL_DEG],
  input  node_state_t cstate [`LDPC_COL_DEG],
  // message stream, 4 cycles latency
  output logic        vsop,
  output logic        vval,
  output logic        veop,
  output node_t       vnode  [`LDPC_COL_DEG],
  output node_state_t vstate [`LDPC_COL_DEG],
  // bit stream, 2 cycles latency
  output logic        bit_sop,
  output logic        bit_val,
  output logic        bit_eop,
  output logic        bit_dat,
  output logic        bit_flip
);

  localparam int DEG         = `LDPC_COL_DEG;
  localparam int STAGES      = $clog2(DEG + 1);        // tree depth, llr is one more leaf
  localparam int LEAVES      = 2**STAGES;
  localparam int SUM_W       = `LDPC_NODE_W + STAGES;  // one growth bit per stage
  localparam int NRM_W       = SUM_W + 3;              // room for the x8 numerator
  localparam int SHIFT       = `LDPC_NODE_W - `LDPC_LLR_W;
  localparam int NORM_FACTOR = `LDPC_NORM_FACTOR;
  localparam bit USE_NORM    = `LDPC_USE_NORM;
  localparam bit USE_SC      = `LDPC_USE_SC_MODE;

  typedef logic signed [SUM_W-1:0] sum_t;

  node_t       leaf     [LEAVES];                // tree inputs
  sum_t        sum_r    [STAGES][LEAVES/2];      // partial sums per stage
  node_t       cnode_d  [STAGES][DEG];           // inputs travel with the tree
  node_state_t cstate_d [STAGES][DEG];
  logic        leq0_d   [STAGES];                // llr <= 0, for the flip flag
  sum_t        ext_r    [DEG];                   // extrinsic sums
  node_state_t ext_st_r [DEG];
  sum_t        norm_r   [DEG];                   // normalized, not saturated yet

  logic [STAGES+1:0] val_sr;                     // strobe delay lines
  logic [STAGES+1:0] sop_sr;
  logic [STAGES+1:0] eop_sr;

  //------------------------------------------------
  // strobes
  //------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_sr <= '0;
    end else if (clkena) begin
      val_sr <= {val_sr[STAGES:0], val};
    end
  end

  always_ff @(posedge iclk) begin
    if (clkena) begin
      sop_sr <= {sop_sr[STAGES:0], sop};
      eop_sr <= {eop_sr[STAGES:0], eop};
    end
  end

  //------------------------------------------------
  // adder tree, llr aligned to message scale
  //------------------------------------------------

  always_comb begin
    for (int i = 0; i < LEAVES; i++) begin
      if (i == 0) begin
        leaf[i] = node_t'(llr) <<< SHIFT;   // channel word in the node format
      end else if (i <= DEG) begin
        leaf[i] = cnode[i-1];
      end else begin
        leaf[i] = '0;                        // pad to a full tree
      end
    end
  end

  for (genvar s = 0; s < STAGES; s++) begin : g_tree
    always_ff @(posedge iclk) begin
      if (clkena) begin
        if (s == 0) begin
          for (int i = 0; i < LEAVES/2; i++) begin
            sum_r[0][i] <= sum_t'(leaf[2*i]) + sum_t'(leaf[2*i+1]);
          end
          cnode_d[0]  <= cnode;
          cstate_d[0] <= cstate;
          leq0_d[0]   <= (llr <= 0);
        end else begin
          for (int i = 0; i < (LEAVES >> (s+1)); i++) begin
            sum_r[s][i] <= sum_r[s-1][2*i] + sum_r[s-1][2*i+1];
          end
          cnode_d[s]  <= cnode_d[s-1];
          cstate_d[s] <= cstate_d[s-1];
          leq0_d[s]   <= leq0_d[s-1];
        end
      end
    end
  end

  //------------------------------------------------
  // hard decision, taken straight off the tree root
  //------------------------------------------------

  assign bit_dat  = sum_r[STAGES-1][0][SUM_W-1];           // negative sum -> 1
  assign bit_flip = bit_dat ^ leq0_d[STAGES-1];            // differs from channel sign
  assign bit_sop  = sop_sr[STAGES-1];
  assign bit_val  = val_sr[STAGES-1];
  assign bit_eop  = eop_sr[STAGES-1];

  //------------------------------------------------
  // extrinsic, sc rule and normalization
  //------------------------------------------------

  always_ff @(posedge iclk) begin
    if (clkena) begin
      for (int c = 0; c < DEG; c++) begin
        ext_r[c]    <= sum_r[STAGES-1][0] - sum_t'(cnode_d[STAGES-1][c]);  // drop own edge
        ext_st_r[c] <= cstate_d[STAGES-1][c];
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (clkena) begin
      for (int c = 0; c < DEG; c++) begin
        // sign changed against a nonzero old message -> erase
        if (USE_SC && !ext_st_r[c].pre_zero && (ext_st_r[c].pre_sign ^ ext_r[c][SUM_W-1])) begin
          norm_r[c] <= '0;
        end else begin
          norm_r[c] <= normalize(ext_r[c]);
        end
      end
    end
  end

  // output side, saturation is combinational after the register
  always_comb begin
    for (int c = 0; c < DEG; c++) begin
      vnode[c]           = saturate(norm_r[c]);
      vstate[c].pre_sign = USE_SC & norm_r[c][SUM_W-1];
      vstate[c].pre_zero = USE_SC & (norm_r[c] == '0);
    end
  end

  assign vsop = sop_sr[STAGES+1];
  assign vval = val_sr[STAGES+1];
  assign veop = eop_sr[STAGES+1];

  //------------------------------------------------
  // arithmetic helpers
  //------------------------------------------------

  // (x * factor + 4) >>> 3, shift-add form of the constant product
  function automatic sum_t normalize(input sum_t x);
    logic signed [NRM_W-1:0] xw;
    logic signed [NRM_W-1:0] tmp;
    xw = x;                                          // sign extend
    case (NORM_FACTOR)
      4:       tmp = (xw <<< 2) + 4;                 // 0.5
      5:       tmp = (xw <<< 2) + xw + 4;            // 0.625
      6:       tmp = (xw <<< 2) + (xw <<< 1) + 4;    // 0.75
      default: tmp = (xw <<< 3) - xw + 4;            // 0.875
    endcase
    return USE_NORM ? sum_t'(tmp[NRM_W-1:3]) : x;
  endfunction

  // clip to the node range, -32..31 for 6 bits
  function automatic node_t saturate(input sum_t x);
    logic sign;
    logic ovf;
    sign = x[SUM_W-1];
    ovf  = (x[SUM_W-1:`LDPC_NODE_W-1] != {(SUM_W-`LDPC_NODE_W+1){sign}});
    return ovf ? {sign, {(`LDPC_NODE_W-1){~sign}}} : x[`LDPC_NODE_W-1:0];
  endfunction

  //------------------------------------------------
  // checks
  //------------------------------------------------

  a_vframe_in_val : assert property (@(posedge iclk) disable iff (ireset)
    (vsop || veop) |-> vval);
  a_bitsop_in_val : assert property (@(posedge iclk) disable iff (ireset)
    bit_sop |-> bit_val);
  a_vval_known    : assert property (@(posedge iclk) disable iff (ireset)
    !$isunknown(vval));

endmodule

/* design/ldpc_dec_vnode_unit.sv */
//------------------------------------------------
// variable node unit top level
// engine plus per frame bit statistics
//------------------------------------------------
`timescale 1ns/1ps
`include "ldpc_dec_cfg.svh"

module ldpc_dec_vnode_unit import ldpc_dec_pkg::*; (
  input  logic                   iclk,
  input  logic                   ireset,
  input  logic                   clkena,
  // input beat, one coded bit
  input  logic                   sop,
  input  logic                   val,
  input  logic                   eop,
  input  llr_t                   llr,
  input  node_t                  cnode  [`LDPC_COL_DEG],
  input  node_state_t            cstate [`LDPC_COL_DEG],
  // message stream back to the check nodes
  output logic                   vsop,
  output logic                   vval,
  output logic                   veop,
  output node_t                  vnode  [`LDPC_COL_DEG],
  output node_state_t            vstate [`LDPC_COL_DEG],
  // hard decisions
  output logic                   bit_val,
  output logic                   bit_dat,
  // frame report
  output logic                   frame_done,
  output logic [`LDPC_CNT_W-1:0] frame_bits,
  output logic [`LDPC_CNT_W-1:0] frame_flips,
  output logic                   seq_err
);

  logic bit_sop;   // engine to stats only
  logic bit_eop;
  logic bit_flip;

  ldpc_dec_vnode_engine u_engine (
    .iclk     (iclk),
    .ireset   (ireset),
    .clkena   (clkena),
    .sop      (sop),
    .val      (val),
    .eop      (eop),
    .llr      (llr),
    .cnode    (cnode),
    .cstate   (cstate),
    .vsop     (vsop),
    .vval     (vval),
    .veop     (veop),
    .vnode    (vnode),
    .vstate   (vstate),
    .bit_sop  (bit_sop),
    .bit_val  (bit_val),
    .bit_eop  (bit_eop),
    .bit_dat  (bit_dat),
    .bit_flip (bit_flip)
  );

  ldpc_dec_bit_stat u_stat (
    .iclk        (iclk),
    .ireset      (ireset),
    .clkena      (clkena),
    .bit_sop     (bit_sop),
    .bit_val     (bit_val),
    .bit_eop     (bit_eop),
    .bit_dat     (bit_dat),
    .bit_flip    (bit_flip),
    .frame_done  (frame_done),
    .seq_err     (seq_err),
    .frame_bits  (frame_bits),
    .frame_flips (frame_flips)
  );

endmodule

/* tb.f */
+incdir+design
design/ldpc_dec_pkg.sv
design/ldpc_dec_vnode_engine.sv
design/ldpc_dec_bit_stat.sv
design/ldpc_dec_vnode_unit.sv
bench/tb_ldpc_dec_vnode_unit.sv
